//--- Bender.yml
package:
  name: uart

sources:
  - common/uart_reg_pkg.sv
  - common/uart_line_pkg.sv
  - design/uart_fifo.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart_apb_regs.sv
  - design/uart.sv
  - target: test
    files:
      - test/uart_properties.sv
      - test/uart_checker.sv
      - test/uart_tb.sv

//--- common/uart_line_pkg.sv
package uart_line_pkg;

    typedef logic [7:0] uart_byte_t; // one 8n1 payload byte.

    typedef logic [15:0] baud_div_t; // pclk cycles per bit minus one.

    // receiver report, valid for one cycle at the stop bit center.
    typedef struct packed {
        uart_byte_t data;      // lsb received first.
        logic       valid;     // one cycle pulse.
        logic       frame_err; // stop bit sampled low.
        logic       busy;      // a frame is in progress.
    } rx_result_t;

endpackage

//--- common/uart_reg_pkg.sv
package uart_reg_pkg;

    // register offsets, compared on paddr[11:0].
    localparam logic [11:0] REG_TXDATA = 12'h000; // write pushes the tx fifo.
    localparam logic [11:0] REG_RXDATA = 12'h004; // read pops the rx fifo.
    localparam logic [11:0] REG_STATUS = 12'h008; // levels and sticky flags.
    localparam logic [11:0] REG_CTRL   = 12'h00C; // baud divisor.

    localparam logic [15:0] DEFAULT_BAUD_DIV = 16'd15; // 16 pclk cycles per bit.

    // status word, bit 5 down to bit 0.
    typedef struct packed {
        logic tx_full;    // bit 5.
        logic tx_empty;   // bit 4.
        logic rx_full;    // bit 3.
        logic rx_empty;   // bit 2.
        logic rx_overrun; // bit 1, write 1 to clear.
        logic frame_err;  // bit 0, write 1 to clear.
    } status_t;

    typedef struct packed {
        logic [15:0] baud_div; // pclk cycles per bit minus one.
    } ctrl_t;

    // apb pins bundled for the register block.
    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } apb_req_t;

endpackage

//--- design/uart.sv
`timescale 1ns/10ps

module uart #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        pclk,
    input  logic        presetn,
    input  logic        psel,
    input  logic        penable,
    input  logic [31:0] paddr,
    input  logic        pwrite,
    input  logic [3:0]  pstrb,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        pready,
    input  logic        uart_rx,
    output logic        uart_tx
);
    import uart_reg_pkg::*;
    import uart_line_pkg::*;

    apb_req_t   apb;
    baud_div_t  baud_div;
    rx_result_t rx_result;
    uart_byte_t tx_wdata;
    uart_byte_t tx_rdata;
    uart_byte_t rx_rdata;
    logic       tx_push;
    logic       tx_pop;
    logic       tx_full;
    logic       tx_empty;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_full;
    logic       rx_empty;

    always_comb begin
        apb.sel    = psel;
        apb.enable = penable;
        apb.write  = pwrite;
        apb.addr   = paddr;
        apb.strb   = pstrb;
        apb.wdata  = pwdata;
    end

    assign pready  = 1'b1;                                  // no wait states.
    assign rx_push = rx_result.valid && !rx_result.frame_err; // good stop bit only.

    uart_apb_regs u_regs (
        .pclk, .presetn, .apb, .prdata, .pslverr,
        .tx_full, .tx_empty, .tx_push, .tx_wdata,
        .rx_empty, .rx_full, .rx_rdata, .rx_pop,
        .rx_result, .baud_div
    );

    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .pclk, .presetn,
        .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
        .rdata(tx_rdata), .full(tx_full), .empty(tx_empty)
    );

    uart_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .pclk, .presetn,
        .push(rx_push), .wdata(rx_result.data), .pop(rx_pop),
        .rdata(rx_rdata), .full(rx_full), .empty(rx_empty)
    );

    uart_tx u_tx (
        .pclk, .presetn, .baud_div,
        .fifo_empty(tx_empty), .fifo_data(tx_rdata), .fifo_pop(tx_pop),
        .uart_tx
    );

    uart_rx u_rx (
        .pclk, .presetn, .baud_div, .uart_rx,
        .result(rx_result)
    );

endmodule

//--- design/uart_apb_regs.sv
`timescale 1ns/10ps

module uart_apb_regs (
    input  logic                       pclk,
    input  logic                       presetn,
    input  uart_reg_pkg::apb_req_t     apb,
    output logic [31:0]                prdata,
    output logic                       pslverr,
    input  logic                       tx_full,
    input  logic                       tx_empty,
    output logic                       tx_push,
    output uart_line_pkg::uart_byte_t  tx_wdata,
    input  logic                       rx_empty,
    input  logic                       rx_full,
    input  uart_line_pkg::uart_byte_t  rx_rdata,
    output logic                       rx_pop,
    input  uart_line_pkg::rx_result_t  rx_result,
    output uart_line_pkg::baud_div_t   baud_div
);
    import uart_reg_pkg::*;
    import uart_line_pkg::*;

    logic        setup;      // psel without penable.
    logic [11:0] offset;
    logic        hit_tx;
    logic        hit_rx;
    logic        hit_status;
    logic        hit_ctrl;
    logic        err;
    logic        rx_overrun;
    logic        frame_err;
    logic [31:0] rd_data;
    status_t     status;
    ctrl_t       ctrl;

    assign setup      = apb.sel && !apb.enable;
    assign offset     = apb.addr[11:0];
    assign hit_tx     = (offset == REG_TXDATA);
    assign hit_rx     = (offset == REG_RXDATA);
    assign hit_status = (offset == REG_STATUS);
    assign hit_ctrl   = (offset == REG_CTRL);

    // unmapped offset, or a byte that the full tx fifo would drop.
    assign err = !(hit_tx || hit_rx || hit_status || hit_ctrl) ||
                 (apb.write && hit_tx && tx_full);

    assign tx_push  = setup && apb.write && hit_tx && !tx_full;
    assign tx_wdata = apb.wdata[7:0];
    assign rx_pop   = setup && !apb.write && hit_rx && !rx_empty; // empty read pops nothing.
    assign baud_div = ctrl.baud_div;

    always_comb begin
        status.tx_full    = tx_full;
        status.tx_empty   = tx_empty;
        status.rx_full    = rx_full;
        status.rx_empty   = rx_empty;
        status.rx_overrun = rx_overrun;
        status.frame_err  = frame_err;
    end

    always_comb begin
        rd_data = '0; // txdata and unmapped read as zero.
        if (hit_rx && !rx_empty) begin
            rd_data = {24'b0, rx_rdata};
        end else if (hit_status) begin
            rd_data = {26'b0, status};
        end else if (hit_ctrl) begin
            rd_data = {16'b0, ctrl};
        end
    end

    // response registered at the setup edge, held over the access phase.
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && err; // drops again after the access edge.
            if (setup && !apb.write) begin
                prdata <= rd_data;
            end
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            ctrl.baud_div <= DEFAULT_BAUD_DIV;
        end else if (setup && apb.write && hit_ctrl) begin
            if (apb.strb[0]) begin
                ctrl.baud_div[7:0] <= apb.wdata[7:0];
            end
            if (apb.strb[1]) begin
                ctrl.baud_div[15:8] <= apb.wdata[15:8];
            end
        end
    end

    // sticky flags, a new event wins over a clear in the same cycle.
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (rx_result.valid && !rx_result.frame_err && rx_full) begin
                rx_overrun <= 1'b1; // byte lost, fifo full.
            end else if (setup && apb.write && hit_status && apb.wdata[1]) begin
                rx_overrun <= 1'b0;
            end
            if (rx_result.valid && rx_result.frame_err) begin
                frame_err <= 1'b1;
            end else if (setup && apb.write && hit_status && apb.wdata[0]) begin
                frame_err <= 1'b0;
            end
        end
    end

endmodule

//--- design/uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     pclk,
    input  logic                     presetn,
    input  logic                     push,
    input  uart_line_pkg::uart_byte_t wdata,
    input  logic                     pop,
    output uart_line_pkg::uart_byte_t rdata,
    output logic                     full,
    output logic                     empty
);
    import uart_line_pkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH); // entry index width.

    uart_byte_t       mem [FIFO_DEPTH]; // storage, no reset needed.
    logic [IDX_W:0]   wptr;             // msb is the wrap bit.
    logic [IDX_W:0]   rptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // push ignored when full.
    assign do_pop  = pop && !empty;  // pop ignored when empty.

    assign empty = (wptr == rptr);
    assign full  = (wptr[IDX_W] != rptr[IDX_W]) &&
                   (wptr[IDX_W-1:0] == rptr[IDX_W-1:0]); // same slot, one lap apart.

    assign rdata = mem[rptr[IDX_W-1:0]]; // head entry, combinational.

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1; // wraps naturally into the lap bit.
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (do_push) begin
            mem[wptr[IDX_W-1:0]] <= wdata;
        end
    end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic                       pclk,
    input  logic                       presetn,
    input  uart_line_pkg::baud_div_t   baud_div,
    input  logic                       uart_rx,
    output uart_line_pkg::rx_result_t  result
);
    import uart_line_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

    rx_state_t  state;
    logic       rx_meta;  // first synchronizer stage.
    logic       rx_sync;  // second synchronizer stage.
    logic       rx_prev;  // for falling edge detection.
    logic       start_edge;
    baud_div_t  div_q;    // divisor frozen at the start edge.
    baud_div_t  half_div;
    baud_div_t  baud_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift;
    logic       valid_q;
    logic       ferr_q;

    assign start_edge = rx_prev && !rx_sync;
    assign half_div   = {1'b0, div_q[15:1]}; // half a bit period.

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state    <= ST_IDLE;
            div_q    <= '0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
            ferr_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0; // single cycle pulse.
            case (state)
                ST_IDLE: begin
                    if (start_edge) begin
                        state    <= ST_START;
                        div_q    <= baud_div;
                        baud_cnt <= '0;
                    end
                end
                ST_START: begin
                    baud_cnt <= (baud_cnt == half_div) ? '0 : baud_cnt + 1'b1;
                    if (baud_cnt == half_div) begin
                        state   <= rx_sync ? ST_IDLE : ST_DATA; // high here is a glitch.
                        bit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    baud_cnt <= (baud_cnt == div_q) ? '0 : baud_cnt + 1'b1;
                    if (baud_cnt == div_q) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                default: begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt == div_q) begin
                        state   <= ST_IDLE; // stop bit center.
                        valid_q <= 1'b1;
                        ferr_q  <= !rx_sync;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == ST_DATA && baud_cnt == div_q) begin
            shift <= {rx_sync, shift[7:1]}; // lsb arrives first.
        end
    end

    always_comb begin
        result.data      = shift;
        result.valid     = valid_q;
        result.frame_err = ferr_q;
        result.busy      = (state != ST_IDLE);
    end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic                      pclk,
    input  logic                      presetn,
    input  uart_line_pkg::baud_div_t  baud_div,
    input  logic                      fifo_empty,
    input  uart_line_pkg::uart_byte_t fifo_data,
    output logic                      fifo_pop,
    output logic                      uart_tx
);
    import uart_line_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} tx_state_t;

    tx_state_t  state;
    baud_div_t  div_q;    // divisor frozen for the frame.
    baud_div_t  baud_cnt; // cycles spent in the current bit.
    logic [2:0] bit_cnt;  // data bit index.
    uart_byte_t shift;    // bit 0 is on the line.
    logic       line_q;   // registered line level.
    logic       bit_done;

    assign bit_done = (baud_cnt == div_q);
    // take the next byte when idle, or straight after the stop bit for back to back frames.
    assign fifo_pop = !fifo_empty &&
                      (state == ST_IDLE || (state == ST_STOP && bit_done));
    assign uart_tx  = line_q;

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state    <= ST_IDLE;
            div_q    <= '0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1; // line idles high.
        end else begin
            if (fifo_pop) begin
                state    <= ST_START;
                div_q    <= baud_div; // new divisor applies from here.
                baud_cnt <= '0;
            end else begin
                case (state)
                    ST_START: begin
                        baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                        if (bit_done) begin
                            state   <= ST_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    ST_DATA: begin
                        baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
                        if (bit_done) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_STOP; // last data bit sent.
                            end
                        end
                    end
                    ST_STOP: begin
                        baud_cnt <= baud_cnt + 1'b1;
                        if (bit_done) begin
                            state <= ST_IDLE; // fifo was empty.
                        end
                    end
                    default: baud_cnt <= '0;
                endcase
            end
            line_q <= (state == ST_START) ? 1'b0 :
                      (state == ST_DATA)  ? shift[0] : 1'b1; // one cycle behind the fsm.
        end
    end

    always_ff @(posedge pclk) begin
        if (fifo_pop) begin
            shift <= fifo_data;
        end else if (state == ST_DATA && bit_done) begin
            shift <= shift >> 1; // lsb first.
        end
    end

endmodule

//--- src.f
common/uart_reg_pkg.sv
common/uart_line_pkg.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_apb_regs.sv
design/uart.sv
test/uart_properties.sv
test/uart_checker.sv
test/uart_tb.sv

//--- test/uart_checker.sv
`timescale 1ns/10ps

module uart_checker (
    input  logic            pclk,
    input  logic            presetn,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [31:0]     paddr,
    input  logic [31:0]     pwdata,
    input  logic [3:0]      pstrb,
    input  logic [31:0]     prdata,
    input  logic            pslverr,
    input  logic            uart_tx,
    input  logic            exp_valid,
    input  logic [31:0]     exp_data,
    input  logic            exp_err,
    input  logic [8*24-1:0] test_name,
    output logic            tx_idle
);
    import uart_reg_pkg::*;
    import uart_line_pkg::*;

    uart_byte_t exp_q [$];                     // bytes accepted by the tx fifo, oldest first.
    baud_div_t  line_div = DEFAULT_BAUD_DIV;   // divisor the dut will use for the next frame.
    logic       busy     = 1'b0;               // a frame is being decoded.
    logic       tx_prev  = 1'b1;
    int         errors   = 0;
    int         checks   = 0;

    // sample at bit centers, counted from the cycle the start edge is seen.
    task automatic decode_frame();
        uart_byte_t got;
        uart_byte_t want;
        baud_div_t  d;
        int         i;
        d    = line_div;
        busy = 1'b1;
        repeat (d / 2) @(posedge pclk);
        if (uart_tx !== 1'b0) begin
            $display("Start bit on uart_tx in test %0s did not stay low up to its center.",
                     test_name);
            errors++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (d + 1) @(posedge pclk);
            got[i] = uart_tx; // lsb first.
        end
        repeat (d + 1) @(posedge pclk);
        checks++;
        if (uart_tx !== 1'b1) begin
            $display("FAIL %0s: stop bit expected 1 actual %b", test_name, uart_tx);
            errors++;
        end
        if (exp_q.size() == 0) begin
            $display("A frame appeared on uart_tx in test %0s with no byte written for it.",
                     test_name);
            errors++;
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                $display("FAIL %0s: tx frame expected 0x%02h actual 0x%02h", test_name, want, got);
                errors++;
            end
        end
        busy = 1'b0;
    endtask

    always @(posedge pclk) begin
        if (presetn && tx_prev && !uart_tx) begin
            decode_frame(); // returns at the stop bit center.
        end
        tx_prev = uart_tx;
    end

    // apb monitor, values seen at the access edge.
    always @(posedge pclk) begin
        if (!presetn) begin
            line_div = DEFAULT_BAUD_DIV;
        end else if (psel && penable) begin
            if (pwrite && paddr[11:0] == REG_TXDATA && exp_valid && !exp_err) begin
                exp_q.push_back(pwdata[7:0]); // accepted byte.
            end
            if (pwrite && paddr[11:0] == REG_CTRL && exp_valid && !exp_err) begin
                if (pstrb[0]) line_div[7:0] = pwdata[7:0];
                if (pstrb[1]) line_div[15:8] = pwdata[15:8];
            end
            if (exp_valid) begin
                checks++;
                if (!pwrite && prdata !== exp_data) begin
                    $display("FAIL %0s: read 0x%03h expected 0x%08h actual 0x%08h",
                             test_name, paddr[11:0], exp_data, prdata);
                    errors++;
                end
                if (pslverr !== exp_err) begin
                    $display("FAIL %0s: pslverr at 0x%03h expected %b actual %b",
                             test_name, paddr[11:0], exp_err, pslverr);
                    errors++;
                end
            end
        end
    end

    always @(posedge pclk) begin
        tx_idle <= (exp_q.size() == 0) && !busy; // nothing left to see on the line.
    end

endmodule

//--- test/uart_properties.sv
`timescale 1ns/10ps

module uart_properties (
    input logic                   pclk,
    input logic                   presetn,
    input uart_reg_pkg::apb_req_t apb,
    input logic                   pslverr,
    input logic                   tx_push,
    input logic                   tx_empty,
    input logic                   rx_pop,
    input logic                   rx_full,
    input logic                   uart_tx
);
    import uart_reg_pkg::*;

    int failures = 0; // failed assertions so far.

    // error response only during the access phase.
    err_in_access: assert property (@(posedge pclk) disable iff (!presetn)
        !(apb.sel && apb.enable) |-> !pslverr)
        else begin
            failures++;
            $error("pslverr high outside an APB access phase");
        end

    // an accepted byte lands in the tx fifo.
    push_lands: assert property (@(posedge pclk) disable iff (!presetn)
        tx_push |=> !tx_empty)
        else begin
            failures++;
            $error("tx_push left the tx fifo empty");
        end

    // a pop always frees a slot in the rx fifo.
    pop_frees: assert property (@(posedge pclk) disable iff (!presetn)
        rx_pop |=> !rx_full)
        else begin
            failures++;
            $error("rx_pop left the rx fifo full");
        end

    // line idles high as reset is released.
    idle_after_reset: assert property (@(posedge pclk)
        $rose(presetn) |-> uart_tx ##1 uart_tx)
        else begin
            failures++;
            $error("uart_tx not high after reset");
        end

endmodule

//--- test/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;
    import uart_reg_pkg::*;
    import uart_line_pkg::*;

    localparam int FIFO_DEPTH   = 4;
    localparam int IDLE_TIMEOUT = 60000; // cycles, covers five slow frames.
    localparam int POLL_TIMEOUT = 2000;  // status reads.

    logic            pclk;
    logic            presetn;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [31:0]     paddr;
    logic [31:0]     pwdata;
    logic [3:0]      pstrb;
    logic [31:0]     prdata;
    logic            pslverr;
    logic            pready;
    logic            uart_rx;
    logic            uart_tx;
    logic            exp_valid;
    logic [31:0]     exp_data;
    logic            exp_err;
    logic            tx_idle;
    logic [8*24-1:0] test_name;
    logic [8*24-1:0] tok;
    logic [8*120-1:0] rest;
    logic [7:0]      op;
    logic [31:0]     a1;
    logic [31:0]     a2;
    logic [31:0]     a3;
    logic [31:0]     rd;
    baud_div_t       cur_div;   // divisor for the serial line driver.
    int              tb_errors;
    int              total;
    int              fd;
    int              r;
    logic            abort;

    uart #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .pclk(pclk), .presetn(presetn), .psel(psel), .penable(penable),
        .paddr(paddr), .pwrite(pwrite), .pstrb(pstrb), .pwdata(pwdata),
        .prdata(prdata), .pslverr(pslverr), .pready(pready),
        .uart_rx(uart_rx), .uart_tx(uart_tx)
    );

    uart_checker u_checker (.*);

    bind uart uart_properties u_props (
        .pclk(pclk), .presetn(presetn), .apb(apb), .pslverr(pslverr),
        .tx_push(tx_push), .tx_empty(tx_empty), .rx_pop(rx_pop), .rx_full(rx_full),
        .uart_tx(uart_tx)
    );

    always #10 pclk = ~pclk; // 20 ns period.

    task automatic note_timeout(input string what);
        $display("Timeout in test %0s while waiting for %0s.", test_name, what);
        tb_errors++;
        abort = 1'b1;
    endtask

    // one apb transfer, setup then access, inputs change on the falling edge.
    task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic check, input logic [31:0] exp_d, input logic exp_e,
                              output logic [31:0] rdata);
        int cnt;
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        pstrb   = 4'hF;
        @(negedge pclk);
        penable   = 1'b1;
        exp_valid = check;
        exp_data  = exp_d;
        exp_err   = exp_e;
        cnt = 0;
        while (!pready && cnt < 8) begin
            @(negedge pclk);
            cnt++;
        end
        if (!pready) note_timeout("pready in an APB access");
        rdata = prdata; // registered at the setup edge.
        @(negedge pclk);
        psel      = 1'b0;
        penable   = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        @(negedge pclk);
        uart_rx = b;
        repeat (cur_div) @(negedge pclk); // held for cur_div+1 cycles.
    endtask

    task automatic send_serial(input logic [7:0] data, input logic stop_bit);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_bit);
        drive_bit(1'b1); // one idle bit.
    endtask

    task automatic wait_tx_idle();
        int cnt;
        cnt = 0;
        @(negedge pclk);
        while (!tx_idle && cnt < IDLE_TIMEOUT) begin
            @(negedge pclk);
            cnt++;
        end
        if (!tx_idle) note_timeout("the transmitter to go idle");
    endtask

    task automatic wait_status_bit(input int idx, input logic val);
        int          polls;
        logic [31:0] st;
        polls = 0;
        apb_access(1'b0, REG_STATUS, 32'h0, 1'b0, 32'h0, 1'b0, st);
        while (st[idx] !== val && polls < POLL_TIMEOUT && !abort) begin
            apb_access(1'b0, REG_STATUS, 32'h0, 1'b0, 32'h0, 1'b0, st);
            polls++;
        end
        if (st[idx] !== val) note_timeout($sformatf("status bit %0d to read %0d", idx, val));
    endtask

    initial begin
        pclk      = 1'b0;
        presetn   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        uart_rx   = 1'b1; // line idles high.
        exp_valid = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        test_name = "reset";
        cur_div   = DEFAULT_BAUD_DIV;
        tb_errors = 0;
        abort     = 1'b0;
        repeat (16) @(negedge pclk);
        presetn = 1'b1;

        fd = $fopen("test/uart_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file test/uart_trace.txt.");
            tb_errors++;
        end
        while (fd != 0 && !abort && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                r = $fgets(rest, fd); // comment line.
            end else begin
                r = $fscanf(fd, "%s %h %h %h", op, a1, a2, a3);
                test_name = tok;
                case (op)
                    "W": begin
                        apb_access(1'b1, a1, a2, 1'b1, 32'h0, a3[0], rd);
                        if (a1[11:0] == REG_CTRL && !a3[0]) cur_div = a2[15:0];
                    end
                    "R": apb_access(1'b0, a1, 32'h0, 1'b1, a2, a3[0], rd);
                    "S": send_serial(a1[7:0], a2[0]);
                    "I": wait_tx_idle();
                    "B": wait_status_bit(a1, a2[0]);
                    default: begin
                        $display("Unknown operation in the trace for test %0s.", test_name);
                        tb_errors++;
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);

        repeat (4) @(negedge pclk);
        if (!tx_idle) begin
            $display("Bytes written to TXDATA were never seen on uart_tx.");
            tb_errors++;
        end
        total = u_checker.errors + tb_errors + DUT.u_props.failures;
        $display("checks %0d, compare errors %0d, testbench errors %0d, assertion failures %0d",
                 u_checker.checks, u_checker.errors, tb_errors, DUT.u_props.failures);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- test/uart_trace.txt
# columns: test op arg1 arg2 arg3, args in hex
# W addr wdata exp_err, R addr exp_rdata exp_err, S byte stop_bit 0, I 0 0 0, B bit value 0
reset_state R 008 00000014 0
reset_state R 00c 0000000f 0
reset_state R 004 00000000 0
tx_order W 000 00000041 0
tx_order W 000 000000a5 0
tx_order W 000 0000000f 0
tx_order I 0 0 0
rx_order S 3c 1 0
rx_order S c3 1 0
rx_order R 004 0000003c 0
rx_order R 004 000000c3 0
rx_order R 004 00000000 0
rx_order R 008 00000014 0
tx_full W 00c 00000100 0
tx_full W 000 00000011 0
tx_full W 000 00000022 0
tx_full W 000 00000033 0
tx_full W 000 00000044 0
tx_full W 000 00000055 0
tx_full W 000 00000066 1
tx_full R 008 00000024 0
tx_full I 0 0 0
tx_full W 00c 0000000f 0
rx_overrun S 01 1 0
rx_overrun S 02 1 0
rx_overrun S 03 1 0
rx_overrun S 04 1 0
rx_overrun S 05 1 0
rx_overrun B 1 1 0
rx_overrun R 008 0000001a 0
rx_overrun R 004 00000001 0
rx_overrun R 004 00000002 0
rx_overrun R 004 00000003 0
rx_overrun R 004 00000004 0
rx_overrun R 008 00000016 0
rx_overrun W 008 00000002 0
rx_overrun R 008 00000014 0
frame_err S 5a 0 0
frame_err B 0 1 0
frame_err R 008 00000015 0
frame_err R 004 00000000 0
frame_err W 008 00000001 0
frame_err R 008 00000014 0
unmapped R 010 00000000 1
unmapped W 020 00001234 1
new_baud W 00c 00000007 0
new_baud R 00c 00000007 0
new_baud W 000 00000096 0
new_baud W 000 00000069 0
new_baud I 0 0 0
new_baud S e7 1 0
new_baud S 18 1 0
new_baud R 004 000000e7 0
new_baud R 004 00000018 0
